/* verilog/dw_pkg.sv */
// Downsizer package with bus field types, burst and response codes and the converted command
`default_nettype none

package dw_pkg;

  // Bus field types
  typedef logic [31:0] addr_t;
  typedef logic [7:0]  len_t;
  typedef logic [2:0]  size_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // Command as seen by the serializer
  typedef struct packed {
    addr_t addr;       // narrow start address
    len_t  len;        // narrow beats minus one
    size_t size;       // narrow beat size
    len_t  orig_len;   // wide beats minus one
    size_t orig_size;  // size of the incoming burst
    logic  split;
    logic  err;
  } narrow_cmd_t;

endpackage

`default_nettype wire

/* verilog/dw_fifo.sv */
// Show-ahead ring-buffer FIFO carrying commands or wide write beats
`timescale 1ns/10ps
`default_nettype none

module dw_fifo #(
  parameter int unsigned FifoDepth = 4,
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o
);

  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  payload_t        mem_q [FifoDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            do_push;
  logic            do_pop;

  assign full_o  = (cnt_q == CntW'(FifoDepth));
  assign empty_o = (cnt_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Head entry is always on the output
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : wr_ptr_q + PtrW'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : rd_ptr_q + PtrW'(1);
      end
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + CntW'(1);
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - CntW'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/aw_converter.sv */
// AW converter that classifies a wide write command and builds the narrow burst
`timescale 1ns/10ps
`default_nettype none

module aw_converter #(
  parameter int unsigned WideWidth   = 64,
  parameter int unsigned NarrowWidth = 32
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  dw_pkg::addr_t       aw_addr_i,
  input  dw_pkg::len_t        aw_len_i,
  input  dw_pkg::size_t       aw_size_i,
  input  dw_pkg::burst_e      aw_burst_i,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  logic                cmd_full_i,
  output dw_pkg::narrow_cmd_t cmd_o,
  output logic                cmd_push_o
);

  import dw_pkg::*;

  localparam int unsigned WideBytes  = WideWidth / 8;
  localparam int unsigned Ratio      = WideWidth / NarrowWidth;
  localparam size_t       WideSize   = size_t'($clog2(WideBytes));
  localparam size_t       NarrowSize = size_t'($clog2(NarrowWidth / 8));

  logic        ready_q;
  logic        wide_aligned;
  logic [15:0] split_beats;

  // AW is held off until the first cycle after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;
    end
  end

  assign aw_ready_o = ready_q & ~cmd_full_i;
  assign cmd_push_o = aw_valid_i & aw_ready_o;

  assign wide_aligned = ((aw_addr_i & addr_t'(WideBytes - 1)) == '0);
  // Narrow beat count of a split burst
  assign split_beats  = ({8'd0, aw_len_i} + 16'd1) * 16'(Ratio);

  always_comb begin
    cmd_o           = '0;
    cmd_o.addr      = aw_addr_i;
    cmd_o.len       = aw_len_i;
    cmd_o.size      = aw_size_i;
    cmd_o.orig_len  = aw_len_i;
    cmd_o.orig_size = aw_size_i;
    cmd_o.err       = 1'b1;
    case (aw_burst_i)
      BURST_INCR: begin
        if (aw_size_i <= NarrowSize) begin
          cmd_o.err = 1'b0;
        end else if (aw_size_i == WideSize && wide_aligned && split_beats <= 16'd256) begin
          cmd_o.len   = len_t'(split_beats - 16'd1);
          cmd_o.size  = NarrowSize;
          cmd_o.split = 1'b1;
          cmd_o.err   = 1'b0;
        end
      end
      // Only a single narrow beat survives these bursts
      BURST_FIXED, BURST_WRAP: begin
        if (aw_len_i == '0 && aw_size_i <= NarrowSize) begin
          cmd_o.err = 1'b0;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/w_serializer.sv */
// W serializer that issues narrow AW and splits, steers or drains wide write beats
`timescale 1ns/10ps
`default_nettype none

module w_serializer #(
  parameter int unsigned WideWidth   = 64,
  parameter int unsigned NarrowWidth = 32
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  dw_pkg::narrow_cmd_t      cmd_i,
  input  logic                     cmd_empty_i,
  output logic                     cmd_pop_o,
  input  logic [WideWidth-1:0]     w_data_i,
  input  logic [WideWidth/8-1:0]   w_strb_i,
  input  logic                     w_last_i,
  input  logic                     w_empty_i,
  output logic                     w_pop_o,
  output dw_pkg::addr_t            m_aw_addr_o,
  output dw_pkg::len_t             m_aw_len_o,
  output dw_pkg::size_t            m_aw_size_o,
  output logic                     m_aw_valid_o,
  input  logic                     m_aw_ready_i,
  output logic [NarrowWidth-1:0]   m_w_data_o,
  output logic [NarrowWidth/8-1:0] m_w_strb_o,
  output logic                     m_w_last_o,
  output logic                     m_w_valid_o,
  input  logic                     m_w_ready_i,
  output logic                     err_req_o,
  input  logic                     err_ack_i,
  output logic                     fwd_o
);

  import dw_pkg::*;

  localparam int unsigned NarrowBytes = NarrowWidth / 8;
  localparam int unsigned Ratio       = WideWidth / NarrowWidth;
  localparam int unsigned LaneW       = $clog2(Ratio);
  localparam int unsigned WideSize    = $clog2(WideWidth / 8);
  localparam int unsigned NarrowSize  = $clog2(NarrowBytes);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_DRAIN
  } state_e;

  state_e           state_q;
  logic             err_req_q;
  addr_t            addr_q;
  len_t             wcnt_q;
  logic [LaneW-1:0] sel;
  logic             wide_done;
  logic             n_xfer;
  logic             drain_pop;
  size_t            step;
  addr_t            step_mask;

  // The command stays at the FIFO head until its burst is done
  assign m_aw_addr_o  = cmd_i.addr;
  assign m_aw_len_o   = cmd_i.len;
  assign m_aw_size_o  = cmd_i.size;
  assign m_aw_valid_o = (state_q == ST_ADDR);
  assign fwd_o        = m_aw_valid_o & m_aw_ready_i;

  // Narrow lane group picked by the running address
  assign sel        = addr_q[WideSize-1:NarrowSize];
  assign m_w_data_o = w_data_i[sel*NarrowWidth +: NarrowWidth];
  assign m_w_strb_o = w_strb_i[sel*NarrowBytes +: NarrowBytes];

  assign m_w_valid_o = (state_q == ST_DATA) & ~w_empty_i;
  assign n_xfer      = m_w_valid_o & m_w_ready_i;
  assign wide_done   = ~cmd_i.split | (sel == LaneW'(Ratio - 1));
  assign m_w_last_o  = wide_done & (wcnt_q == cmd_i.orig_len);

  assign drain_pop = (state_q == ST_DRAIN) & ~w_empty_i;
  assign w_pop_o   = (n_xfer & wide_done) | drain_pop;
  assign cmd_pop_o = (n_xfer & m_w_last_o) | (drain_pop & w_last_i);
  assign err_req_o = err_req_q;

  // Address step of one narrow beat
  assign step      = cmd_i.size;
  assign step_mask = (addr_t'(1) << step) - addr_t'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      err_req_q <= 1'b0;
    end else begin
      if (err_ack_i) begin
        err_req_q <= 1'b0;
      end
      case (state_q)
        // Wait for a pending local error to be answered first
        ST_IDLE: begin
          if (!cmd_empty_i && !err_req_q) begin
            state_q <= cmd_i.err ? ST_DRAIN : ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (m_aw_ready_i) begin
            state_q <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (n_xfer && m_w_last_o) begin
            state_q <= ST_IDLE;
          end
        end
        ST_DRAIN: begin
          if (drain_pop && w_last_i) begin
            err_req_q <= 1'b1;
            state_q   <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Beat position within the burst
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE) begin
      addr_q <= cmd_i.addr;
      wcnt_q <= '0;
    end else if (n_xfer) begin
      addr_q <= (addr_q & ~step_mask) + (step_mask + addr_t'(1));
      if (wide_done) begin
        wcnt_q <= wcnt_q + len_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/b_responder.sv */
// B responder that forwards narrow-side responses and inserts local SLVERR in order
`timescale 1ns/10ps
`default_nettype none

module b_responder (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          fwd_i,
  input  dw_pkg::resp_e m_b_resp_i,
  input  logic          m_b_valid_i,
  output logic          m_b_ready_o,
  output dw_pkg::resp_e b_resp_o,
  output logic          b_valid_o,
  input  logic          b_ready_i,
  input  logic          err_req_i,
  output logic          err_ack_o
);

  import dw_pkg::*;

  // Forwarded bursts still waiting for their B
  logic [7:0] cnt_q;
  logic       local_sel;
  logic       b_done;

  // Local error goes out only once all earlier bursts are answered
  assign local_sel = err_req_i & (cnt_q == '0);

  assign b_valid_o   = local_sel | m_b_valid_i;
  assign b_resp_o    = local_sel ? RESP_SLVERR : m_b_resp_i;
  assign m_b_ready_o = b_ready_i & ~local_sel;
  assign err_ack_o   = local_sel & b_ready_i;
  assign b_done      = m_b_valid_i & m_b_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      case ({fwd_i, b_done})
        2'b10:   cnt_q <= cnt_q + 8'd1;
        2'b01:   cnt_q <= cnt_q - 8'd1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/dw_write_top.sv */
// Write-path data-width downsizer top with converter, FIFOs, serializer and responder
`timescale 1ns/10ps
`default_nettype none

module dw_write_top #(
  parameter int unsigned WideWidth   = 64,
  parameter int unsigned NarrowWidth = 32,
  parameter int unsigned FifoDepth   = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Wide side
  input  dw_pkg::addr_t            aw_addr_i,
  input  dw_pkg::len_t             aw_len_i,
  input  dw_pkg::size_t            aw_size_i,
  input  dw_pkg::burst_e           aw_burst_i,
  input  logic                     aw_valid_i,
  output logic                     aw_ready_o,
  input  logic [WideWidth-1:0]     w_data_i,
  input  logic [WideWidth/8-1:0]   w_strb_i,
  input  logic                     w_last_i,
  input  logic                     w_valid_i,
  output logic                     w_ready_o,
  output dw_pkg::resp_e            b_resp_o,
  output logic                     b_valid_o,
  input  logic                     b_ready_i,
  // Narrow side
  output dw_pkg::addr_t            m_aw_addr_o,
  output dw_pkg::len_t             m_aw_len_o,
  output dw_pkg::size_t            m_aw_size_o,
  output logic                     m_aw_valid_o,
  input  logic                     m_aw_ready_i,
  output logic [NarrowWidth-1:0]   m_w_data_o,
  output logic [NarrowWidth/8-1:0] m_w_strb_o,
  output logic                     m_w_last_o,
  output logic                     m_w_valid_o,
  input  logic                     m_w_ready_i,
  input  dw_pkg::resp_e            m_b_resp_i,
  input  logic                     m_b_valid_i,
  output logic                     m_b_ready_o
);

  import dw_pkg::*;

  typedef struct packed {
    logic [WideWidth-1:0]   data;
    logic [WideWidth/8-1:0] strb;
    logic                   last;
  } beat_t;

  narrow_cmd_t cmd_in;
  narrow_cmd_t cmd_head;
  logic        cmd_push;
  logic        cmd_full;
  logic        cmd_pop;
  logic        cmd_empty;
  beat_t       w_in;
  beat_t       w_head;
  logic        w_full;
  logic        w_pop;
  logic        w_empty;
  logic        err_req;
  logic        err_ack;
  logic        fwd;

  aw_converter #(
    .WideWidth  (WideWidth),
    .NarrowWidth(NarrowWidth)
  ) u_aw_converter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .aw_addr_i (aw_addr_i),
    .aw_len_i  (aw_len_i),
    .aw_size_i (aw_size_i),
    .aw_burst_i(aw_burst_i),
    .aw_valid_i(aw_valid_i),
    .aw_ready_o(aw_ready_o),
    .cmd_full_i(cmd_full),
    .cmd_o     (cmd_in),
    .cmd_push_o(cmd_push)
  );

  dw_fifo #(
    .FifoDepth(FifoDepth),
    .payload_t(narrow_cmd_t)
  ) u_cmd_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (cmd_push),
    .data_i (cmd_in),
    .full_o (cmd_full),
    .pop_i  (cmd_pop),
    .data_o (cmd_head),
    .empty_o(cmd_empty)
  );

  // Upstream W goes straight into the beat FIFO
  assign w_in.data = w_data_i;
  assign w_in.strb = w_strb_i;
  assign w_in.last = w_last_i;
  assign w_ready_o = ~w_full;

  dw_fifo #(
    .FifoDepth(FifoDepth),
    .payload_t(beat_t)
  ) u_w_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (w_valid_i & w_ready_o),
    .data_i (w_in),
    .full_o (w_full),
    .pop_i  (w_pop),
    .data_o (w_head),
    .empty_o(w_empty)
  );

  w_serializer #(
    .WideWidth  (WideWidth),
    .NarrowWidth(NarrowWidth)
  ) u_w_serializer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_i       (cmd_head),
    .cmd_empty_i (cmd_empty),
    .cmd_pop_o   (cmd_pop),
    .w_data_i    (w_head.data),
    .w_strb_i    (w_head.strb),
    .w_last_i    (w_head.last),
    .w_empty_i   (w_empty),
    .w_pop_o     (w_pop),
    .m_aw_addr_o (m_aw_addr_o),
    .m_aw_len_o  (m_aw_len_o),
    .m_aw_size_o (m_aw_size_o),
    .m_aw_valid_o(m_aw_valid_o),
    .m_aw_ready_i(m_aw_ready_i),
    .m_w_data_o  (m_w_data_o),
    .m_w_strb_o  (m_w_strb_o),
    .m_w_last_o  (m_w_last_o),
    .m_w_valid_o (m_w_valid_o),
    .m_w_ready_i (m_w_ready_i),
    .err_req_o   (err_req),
    .err_ack_i   (err_ack),
    .fwd_o       (fwd)
  );

  b_responder u_b_responder (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .fwd_i      (fwd),
    .m_b_resp_i (m_b_resp_i),
    .m_b_valid_i(m_b_valid_i),
    .m_b_ready_o(m_b_ready_o),
    .b_resp_o   (b_resp_o),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .err_req_i  (err_req),
    .err_ack_o  (err_ack)
  );

endmodule

`default_nettype wire

/* verification/dw_tb_table.svh */
// Test bursts for the write downsizer with their expected narrow command and response
`ifndef DW_TB_TABLE_SVH
`define DW_TB_TABLE_SVH

// Columns are address, wide length, size, burst type, expected narrow length,
// expected narrow size, expected response and random gaps on the narrow readies
localparam int unsigned NumTests = 14;

localparam test_t TestTable [NumTests] = '{
  // Full-width split
  '{32'h0000_1000, 8'd3,   3'd3, BURST_INCR,  8'd7,   3'd2, RESP_OKAY,   1'b0},
  // Narrow-size pass-through, upper lane first
  '{32'h0000_2004, 8'd2,   3'd2, BURST_INCR,  8'd2,   3'd2, RESP_OKAY,   1'b0},
  // Bytes and halfwords crossing a lane group
  '{32'h0000_3001, 8'd5,   3'd0, BURST_INCR,  8'd5,   3'd0, RESP_OKAY,   1'b0},
  '{32'h0000_3102, 8'd3,   3'd1, BURST_INCR,  8'd3,   3'd1, RESP_OKAY,   1'b0},
  // Single-beat FIXED and WRAP
  '{32'h0000_4006, 8'd0,   3'd1, BURST_FIXED, 8'd0,   3'd1, RESP_OKAY,   1'b0},
  '{32'h0000_5008, 8'd0,   3'd2, BURST_WRAP,  8'd0,   3'd2, RESP_OKAY,   1'b0},
  // Multi-beat FIXED and WRAP are rejected
  '{32'h0000_6000, 8'd1,   3'd2, BURST_FIXED, 8'd0,   3'd0, RESP_SLVERR, 1'b0},
  '{32'h0000_5040, 8'd3,   3'd2, BURST_WRAP,  8'd0,   3'd0, RESP_SLVERR, 1'b0},
  // Misaligned wide burst, then a split of 258 narrow beats
  '{32'h0000_7004, 8'd1,   3'd3, BURST_INCR,  8'd0,   3'd0, RESP_SLVERR, 1'b0},
  '{32'h0000_8000, 8'd128, 3'd3, BURST_INCR,  8'd0,   3'd0, RESP_SLVERR, 1'b0},
  // Good bursts after the errors, the second one exactly 256 narrow beats
  '{32'h0000_9000, 8'd1,   3'd3, BURST_INCR,  8'd3,   3'd2, RESP_OKAY,   1'b0},
  '{32'h0000_a000, 8'd127, 3'd3, BURST_INCR,  8'd255, 3'd2, RESP_OKAY,   1'b0},
  // Same as the first split and pass bursts, with narrow back-pressure
  '{32'h0000_1000, 8'd3,   3'd3, BURST_INCR,  8'd7,   3'd2, RESP_OKAY,   1'b1},
  '{32'h0000_2004, 8'd2,   3'd2, BURST_INCR,  8'd2,   3'd2, RESP_OKAY,   1'b1}
};

`endif

/* verification/dw_write_tb.sv */
// Testbench for the write downsizer with upstream driver, narrow slave model and checks
`timescale 1ns/10ps
`default_nettype none

module dw_write_tb;

  import dw_pkg::*;

  localparam int unsigned WideWidth   = 64;
  localparam int unsigned NarrowWidth = 32;
  localparam int unsigned FifoDepth   = 4;
  localparam int unsigned WideBytes   = WideWidth / 8;
  localparam int unsigned NarrowBytes = NarrowWidth / 8;
  localparam int unsigned StrbW       = WideBytes;
  localparam int unsigned Ratio       = WideWidth / NarrowWidth;
  localparam int unsigned ClkPeriod   = 4;
  localparam logic [31:0] LfsrPoly    = 32'h8020_0003;

  typedef struct packed {
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
    len_t   exp_len;
    size_t  exp_size;
    resp_e  exp_resp;
    logic   gaps;
  } test_t;

  // Narrow beat as {data, strb, last}
  typedef logic [NarrowWidth+NarrowBytes:0] nbeat_t;

  `include "dw_tb_table.svh"

  // Room for the longest burst in every entry, with margin for gaps
  localparam int unsigned WatchCycles = NumTests * 256 * 8;

  logic                     clk_i = 1'b0;
  logic                     rst_ni;
  addr_t                    aw_addr_i;
  len_t                     aw_len_i;
  size_t                    aw_size_i;
  burst_e                   aw_burst_i;
  logic                     aw_valid_i;
  logic                     aw_ready_o;
  logic [WideWidth-1:0]     w_data_i;
  logic [StrbW-1:0]         w_strb_i;
  logic                     w_last_i;
  logic                     w_valid_i;
  logic                     w_ready_o;
  resp_e                    b_resp_o;
  logic                     b_valid_o;
  logic                     b_ready_i;
  addr_t                    m_aw_addr_o;
  len_t                     m_aw_len_o;
  size_t                    m_aw_size_o;
  logic                     m_aw_valid_o;
  logic                     m_aw_ready_i = 1'b0;
  logic [NarrowWidth-1:0]   m_w_data_o;
  logic [NarrowBytes-1:0]   m_w_strb_o;
  logic                     m_w_last_o;
  logic                     m_w_valid_o;
  logic                     m_w_ready_i = 1'b0;
  resp_e                    m_b_resp_i = RESP_OKAY;
  logic                     m_b_valid_i = 1'b0;
  logic                     m_b_ready_o;

  logic [31:0] lfsr_q = 32'hdbfe;
  int unsigned aw_idx_q [$];
  nbeat_t      exp_w_q [$];
  nbeat_t      exp_beat;
  int unsigned aw_idx;
  int unsigned resp_cnt = 0;
  int unsigned b_pend = 0;
  logic        w_gaps = 1'b0;

  dw_write_top #(
    .WideWidth  (WideWidth),
    .NarrowWidth(NarrowWidth),
    .FifoDepth  (FifoDepth)
  ) u_dut (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  function automatic logic rand_bit();
    logic bit_out;
    bit_out = lfsr_q[0];
    lfsr_q  = (lfsr_q >> 1) ^ (bit_out ? LfsrPoly : 32'h0);
    return bit_out;
  endfunction

  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] r;
    int unsigned j;
    r = '0;
    for (j = 0; j < n; j++) begin
      r = {r[62:0], rand_bit()};
    end
    return r;
  endfunction

  // Byte lanes of the wide bus that a beat of this size at this address uses
  function automatic logic [StrbW-1:0] lane_mask(input addr_t a, input size_t s);
    int unsigned nb;
    int unsigned off;
    nb  = 1 << s;
    off = (a % WideBytes) / nb * nb;
    return StrbW'(((1 << nb) - 1) << off);
  endfunction

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp));
    end
  endtask

  task automatic drive_aw();
    int unsigned i;
    for (i = 0; i < NumTests; i++) begin
      @(negedge clk_i);
      aw_addr_i  = TestTable[i].addr;
      aw_len_i   = TestTable[i].len;
      aw_size_i  = TestTable[i].size;
      aw_burst_i = TestTable[i].burst;
      aw_valid_i = 1'b1;
      @(posedge clk_i);
      while (!aw_ready_o) @(posedge clk_i);
    end
    @(negedge clk_i);
    aw_valid_i = 1'b0;
  endtask

  task automatic drive_w();
    int unsigned          i;
    int unsigned          b;
    int unsigned          k;
    int unsigned          lane;
    addr_t                baddr;
    logic [WideWidth-1:0] data;
    logic [StrbW-1:0]     strb;
    logic                 last;
    for (i = 0; i < NumTests; i++) begin
      for (b = 0; b <= TestTable[i].len; b++) begin
        @(negedge clk_i);
        w_valid_i = 1'b0;
        // Occasional idle cycle on the wide W channel
        if (rand_bits(2) == 0) begin
          @(negedge clk_i);
        end
        if (TestTable[i].burst != BURST_INCR || b == 0) begin
          baddr = TestTable[i].addr;
        end else begin
          baddr = ((TestTable[i].addr >> TestTable[i].size) + addr_t'(b)) << TestTable[i].size;
        end
        data = rand_bits(WideWidth);
        strb = lane_mask(baddr, TestTable[i].size) & StrbW'(rand_bits(StrbW));
        last = (b == TestTable[i].len);
        if (TestTable[i].exp_resp == RESP_OKAY) begin
          if (TestTable[i].size > TestTable[i].exp_size) begin
            // Full-width beat comes out as lane groups, low lanes first
            for (k = 0; k < Ratio; k++) begin
              exp_w_q.push_back({data[k*NarrowWidth +: NarrowWidth],
                                 strb[k*NarrowBytes +: NarrowBytes], last && (k == Ratio - 1)});
            end
          end else begin
            lane = (baddr % WideBytes) / NarrowBytes;
            exp_w_q.push_back({data[lane*NarrowWidth +: NarrowWidth],
                               strb[lane*NarrowBytes +: NarrowBytes], last});
          end
        end
        w_data_i  = data;
        w_strb_i  = strb;
        w_last_i  = last;
        w_valid_i = 1'b1;
        @(posedge clk_i);
        while (!w_ready_o) @(posedge clk_i);
      end
    end
    @(negedge clk_i);
    w_valid_i = 1'b0;
  endtask

  // Narrow slave readies and B, driven on the falling edge
  always @(negedge clk_i) begin
    m_aw_ready_i = (aw_idx_q.size() != 0 && TestTable[aw_idx_q[0]].gaps) ? rand_bit() : 1'b1;
    m_w_ready_i  = w_gaps ? rand_bit() : 1'b1;
    m_b_valid_i  = (b_pend != 0);
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (m_aw_valid_o && m_aw_ready_i) begin
        if (aw_idx_q.size() == 0) begin
          stop_with_error("Narrow AW issued with no forwarded burst pending");
        end else begin
          aw_idx = aw_idx_q.pop_front();
          compare("m_aw_addr_o", 64'(m_aw_addr_o), 64'(TestTable[aw_idx].addr));
          compare("m_aw_len_o", 64'(m_aw_len_o), 64'(TestTable[aw_idx].exp_len));
          compare("m_aw_size_o", 64'(m_aw_size_o), 64'(TestTable[aw_idx].exp_size));
          w_gaps = TestTable[aw_idx].gaps;
        end
      end
      if (m_w_valid_o && m_w_ready_i) begin
        if (exp_w_q.size() == 0) begin
          stop_with_error("Narrow W beat seen with no beat expected");
        end else begin
          exp_beat = exp_w_q.pop_front();
          compare("m_w_data_o", 64'(m_w_data_o), 64'(exp_beat[NarrowWidth+NarrowBytes:NarrowBytes+1]));
          compare("m_w_strb_o", 64'(m_w_strb_o), 64'(exp_beat[NarrowBytes:1]));
          compare("m_w_last_o", 64'(m_w_last_o), 64'(exp_beat[0]));
          if (m_w_last_o) begin
            b_pend = b_pend + 1;
          end
        end
      end
      if (m_b_valid_i && m_b_ready_o) begin
        b_pend = b_pend - 1;
      end
      // Responses must come back in table order
      if (b_valid_o && b_ready_i) begin
        if (resp_cnt >= NumTests) begin
          stop_with_error("Upstream B response arrived after the last burst");
        end else begin
          compare("b_resp_o", 64'(b_resp_o), 64'(TestTable[resp_cnt].exp_resp));
          resp_cnt = resp_cnt + 1;
        end
      end
    end
  end

  initial begin
    repeat (WatchCycles) @(posedge clk_i);
    stop_with_error("Watchdog expired before all responses arrived");
  end

  initial begin
    int unsigned i;
    rst_ni     = 1'b0;
    aw_addr_i  = '0;
    aw_len_i   = '0;
    aw_size_i  = '0;
    aw_burst_i = BURST_INCR;
    aw_valid_i = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    w_valid_i  = 1'b0;
    b_ready_i  = 1'b1;
    // Bursts that must show up on the narrow side, in order
    for (i = 0; i < NumTests; i++) begin
      if (TestTable[i].exp_resp == RESP_OKAY) begin
        aw_idx_q.push_back(i);
      end
    end
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    fork
      drive_aw();
      drive_w();
    join
    wait (resp_cnt == NumTests);
    repeat (4) @(negedge clk_i);
    if (aw_idx_q.size() == 0 && exp_w_q.size() == 0 && b_pend == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_with_error("Narrow commands or beats still outstanding at the end");
    end
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verification
verilog/dw_pkg.sv
verilog/dw_fifo.sv
verilog/aw_converter.sv
verilog/w_serializer.sv
verilog/b_responder.sv
verilog/dw_write_top.sv
verification/dw_write_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the write downsizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module dw_write_tb \
  -f filelist.f --Mdir obj_dir -o dw_write_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/dw_write_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
  echo "Simulation PASSED"
  exit 0
fi
echo "Simulation FAILED, no pass line in sim.log"
exit 1
